/* build.f */
+incdir+rtl
rtl/tx_dsp_pkg.sv
rtl/tx_setting_decode.sv
rtl/tx_cic_interp.sv
rtl/tx_nco_rotate.sv
rtl/tx_output_scale.sv
rtl/tx_dsp_top.sv
tb/tb_clkgen.sv
tb/tx_dsp_assert.sv
tb/tx_dsp_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tx_dsp_tb -o tx_dsp_sim
./obj_dir/tx_dsp_sim 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

/* tb/tx_dsp_tb.sv */
// Directed tests for tx_dsp_top; inputs move 10 ns after posedge, outputs are read at negedge
`timescale 1ns/100ps
`include "tx_dsp_params.svh"

module tx_dsp_tb
   import tx_dsp_pkg::*;
();

   localparam int TEST_CYCLES = 2770;   // Reset, strobe, DC, rotation and write tests
   localparam int CYCLE_LIMIT = TEST_CYCLES * 12 / 10;
   localparam int LATENCY     = 19;
   localparam int SETTLE      = 40;     // CIC settling margin for rates up to 8

   logic          clk;
   logic          rst;
   logic          set_stb;
   logic [7:0]    set_addr;
   setting_word_u set_data;
   logic          run;
   iq_sample_t    sample;
   logic          sample_stb;
   iq_dac_t       tx;
   logic [31:0]   lfsr;
   scale_t        cur_scale;
   logic [31:0]   cur_inc;
   int            cycle_cnt = 0;

   tb_clkgen u_clkgen (
      .clk_o (clk),
      .rst_o (rst)
   );

   tx_dsp_top uut (
      .clk          (clk),
      .rst          (rst),
      .set_stb_i    (set_stb),
      .set_addr_i   (set_addr),
      .set_data_i   (set_data),
      .run_i        (run),
      .sample_i     (sample),
      .sample_stb_o (sample_stb),
      .tx_o         (tx)
   );

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "stopping at first error");
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT)
         stop_on_error($sformatf("Timeout, tests still running after %0d cycles", cycle_cnt));
   end

   task automatic check_dac(input string name, input iq_dac_t got, input iq_dac_t exp);
      if (got !== exp)
         stop_on_error($sformatf("CHECK FAILED %s: got i=%h q=%h, expected i=%h q=%h",
                                 name, got.i, got.q, exp.i, exp.q));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
         stop_on_error($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
   endtask

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int b = 0; b < n; b++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   // Settled CIC output through CORDIC and scaler, angle in 2^-24 turns
   function automatic iq_dac_t ref_output(input iq_sample_t s, input logic [23:0] angle,
                                          input scale_t scale);
      longint             x;
      longint             y;
      longint             t;
      logic [23:0]        z;
      logic signed [63:0] p_i;
      logic signed [63:0] p_q;
      x = longint'(s.i) * 256;   // Two CIC guard bits, six alignment bits
      y = longint'(s.q) * 256;
      z = angle;
      if (z[23] != z[22]) begin   // Half a turn first
         x = -x;
         y = -y;
         z = z + 24'h800000;
      end
      for (int k = 0; k < `TX_CORDIC_STAGES; k++) begin
         t = x;
         if (z[23]) begin
            x = x + (y >>> k);
            y = y - (t >>> k);
            z = z + cordic_atan_table[k];
         end else begin
            x = x - (y >>> k);
            y = y + (t >>> k);
            z = z - cordic_atan_table[k];
         end
      end
      p_i = (x >>> 8) * scale.scale_i;   // Top 18 of 26 bits
      p_q = (y >>> 8) * scale.scale_q;
      return '{i: p_i[28:5], q: p_q[28:5]};
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_stb      = 1'b1;
      set_addr     = addr;
      set_data.raw = data;
      next_cycle();
      set_stb = 1'b0;
   endtask

   task automatic count_strobes(input int cycles, output int count);
      count = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (sample_stb)
            count++;
         next_cycle();
      end
   endtask

   // Returns in running cycle 0
   task automatic start_run(input logic [31:0] phase_inc, input scale_t scale,
                            input logic [2:0] log2_rate);
      cur_inc   = phase_inc;
      cur_scale = scale;
      run       = 1'b0;   // Clears phase, strober and integrators
      next_cycle();
      write_setting(`TX_ADDR_FREQ, phase_inc);
      write_setting(`TX_ADDR_SCALE, scale);
      write_setting(`TX_ADDR_RATE, {29'd0, log2_rate});
      next_cycle();
      run = 1'b1;
   endtask

   task automatic test_reset();
      int n;
      @(negedge clk);
      check_dac("tx_o after reset", tx, '0);
      count_strobes(8, n);
      check_count("sample_stb_o while idle", n, 0);
   endtask

   task automatic test_strobe_rate(input logic [2:0] log2_rate);
      int n;
      start_run(32'd0, '0, log2_rate);
      count_strobes(512, n);
      check_count($sformatf("sample_stb_o count at log2 rate %0d", log2_rate),
                  n, 512 >> log2_rate);
   endtask

   task automatic test_dc();
      logic [31:0] bits;
      iq_dac_t     exp;
      draw_bits(32, bits);
      sample = bits;
      draw_bits(32, bits);
      start_run(32'd0, bits, 3'd3);
      repeat (300) next_cycle();
      exp = ref_output(sample, 24'd0, cur_scale);
      repeat (16) begin
         @(negedge clk);
         check_dac("tx_o on DC path", tx, exp);
         next_cycle();
      end
   endtask

   task automatic test_rotation(input bit restart);
      logic [31:0] bits;
      logic [31:0] phase;
      if (restart) begin
         run = 1'b0;   // One stopped cycle
         next_cycle();
         run = 1'b1;
      end else begin
         draw_bits(32, bits);
         sample = bits;
         draw_bits(32, bits);
         start_run(bits, cur_scale, 3'd2);
      end
      for (int c = 0; c < SETTLE + LATENCY + 64; c++) begin
         @(negedge clk);
         phase = 32'(c - LATENCY) * cur_inc;
         if (c >= SETTLE + LATENCY)
            check_dac("tx_o while rotating", tx, ref_output(sample, phase[31:8], cur_scale));
         next_cycle();
      end
   endtask

   task automatic test_rate_change();
      int n;
      write_setting(`TX_ADDR_RATE, 32'd0);   // Strobe every cycle
      next_cycle();
      set_stb  = 1'b1;
      set_addr = `TX_ADDR_RATE;
      set_data = '0;
      count_strobes(1, n);
      check_count("sample_stb_o in rate write cycle", n, 1);
      set_stb = 1'b0;
      count_strobes(1, n);
      check_count("sample_stb_o in rate change cycle", n, 0);
      count_strobes(8, n);
      check_count("sample_stb_o after rate change", n, 8);
   endtask

   task automatic test_ignored_write();
      logic [31:0] bits;
      iq_dac_t     exp;
      int          n;
      draw_bits(32, bits);
      start_run(32'd0, cur_scale, 3'd3);
      repeat (100) next_cycle();
      exp = ref_output(sample, 24'd0, cur_scale);
      write_setting(8'd5, bits);
      n = 0;
      repeat (512) begin
         @(negedge clk);
         check_dac("tx_o after write to unused address", tx, exp);
         if (sample_stb)
            n++;
         next_cycle();
      end
      check_count("sample_stb_o count after unused write", n, 64);
   endtask

   initial begin
      set_stb   = 1'b0;
      set_addr  = '0;
      set_data  = '0;
      run       = 1'b0;
      sample    = '0;
      lfsr      = 32'h4e67;
      cur_scale = '0;
      cur_inc   = '0;
      @(negedge rst);
      test_reset();
      test_strobe_rate(3'd0);
      test_strobe_rate(3'd3);
      test_strobe_rate(3'd7);
      test_dc();
      test_rotation(1'b0);
      test_rate_change();
      test_rotation(1'b1);   // Phase restarts from 0
      test_ignored_write();
      $display("sim passed");
      $finish;
   end

endmodule

/* tb/tx_dsp_assert.sv */
// Bound to tx_dsp_top; strobe checks are off during reset, the output check covers reset itself
`timescale 1ns/100ps
`include "tx_dsp_params.svh"

module tx_dsp_assert
   import tx_dsp_pkg::*;
(
   input logic       clk,
   input logic       rst,
   input logic       run_i,
   input logic       set_stb_i,
   input logic [7:0] set_addr_i,
   input logic       sample_stb_i,
   input iq_dac_t    tx_i
);

   // No sample requests while stopped
   a_idle_no_stb : assert property (@(posedge clk) disable iff (rst) !run_i |-> !sample_stb_i)
      else $error("sample strobe while run is low");

   // A rate write on the bus pauses the strober in the following cycle
   a_rate_pause : assert property (@(posedge clk) disable iff (rst)
      (set_stb_i && set_addr_i == `TX_ADDR_RATE) |=> !sample_stb_i)
      else $error("sample strobe during rate change");

   a_reset_clears_tx : assert property (@(posedge clk) rst |=> (tx_i == '0))
      else $error("tx output not zero after reset");

endmodule

bind tx_dsp_top tx_dsp_assert u_assert (
   .clk          (clk),
   .rst          (rst),
   .run_i        (run_i),
   .set_stb_i    (set_stb_i),
   .set_addr_i   (set_addr_i),
   .sample_stb_i (sample_stb_o),
   .tx_i         (tx_o)
);

/* tb/tb_clkgen.sv */
// Free-running 100 ns clock; reset is high for the first 3 rising edges and drops 10 ns after the third
`timescale 1ns/100ps

module tb_clkgen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (3) @(posedge clk_o);
      #10 rst_o = 1'b0;   // Same offset as the other stimulus
   end

endmodule

/* rtl/tx_dsp_top.sv */
// TX DSP core top; no back-pressure, so the framer must answer every sample strobe in time
`timescale 1ns/100ps

module tx_dsp_top
   import tx_dsp_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          set_stb_i,
   input  logic [7:0]    set_addr_i,
   input  setting_word_u set_data_i,
   input  logic          run_i,
   input  iq_sample_t    sample_i,
   output logic          sample_stb_o,
   output iq_dac_t       tx_o
);

   tx_cfg_t  cfg;
   logic     rate_change;
   iq_wide_t cic_out;
   iq_wide_t rot_out;

   tx_setting_decode u_decode (
      .clk           (clk),
      .rst           (rst),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .cfg_o         (cfg),
      .rate_change_o (rate_change)
   );

   tx_cic_interp u_cic (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .rate_change_i (rate_change),
      .log2_rate_i   (cfg.log2_rate),
      .sample_i      (sample_i),
      .sample_stb_o  (sample_stb_o),
      .cic_o         (cic_out)
   );

   tx_nco_rotate u_nco (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .phase_inc_i (cfg.phase_inc),
      .data_i      (cic_out),
      .data_o      (rot_out)
   );

   tx_output_scale u_scale (
      .clk     (clk),
      .rst     (rst),
      .data_i  (rot_out),
      .scale_i (cfg.scale),
      .tx_o    (tx_o)
   );

endmodule

/* rtl/tx_output_scale.sv */
// Signed per-channel gain, 2 cycles; output is product bits 28 down to 5, no saturation
`timescale 1ns/100ps
`include "tx_dsp_params.svh"

module tx_output_scale
   import tx_dsp_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  iq_wide_t data_i,
   input  scale_t   scale_i,
   output iq_dac_t  tx_o
);

   localparam int PW  = 2 * `TX_BB_W;
   localparam int LSB = 5;

   logic signed [`TX_BB_W-1:0] a_i;
   logic signed [`TX_BB_W-1:0] a_q;
   logic signed [15:0]         b_i;
   logic signed [15:0]         b_q;
   logic signed [PW-1:0]       prod_i;
   logic signed [PW-1:0]       prod_q;

   // Operand registers, then product registers
   always_ff @(posedge clk) begin
      if (rst) begin
         a_i    <= '0;
         a_q    <= '0;
         b_i    <= '0;
         b_q    <= '0;
         prod_i <= '0;
         prod_q <= '0;
      end else begin
         a_i    <= data_i.i;
         a_q    <= data_i.q;
         b_i    <= scale_i.scale_i;
         b_q    <= scale_i.scale_q;
         prod_i <= a_i * b_i;
         prod_q <= a_q * b_q;
      end
   end

   assign tx_o = '{i: prod_i[LSB +: `TX_DAC_W], q: prod_q[LSB +: `TX_DAC_W]};

endmodule

/* rtl/tx_nco_rotate.sv */
// NCO plus 16-stage CORDIC, 17 cycles deep; CORDIC gain of about 1.647 is not compensated
`timescale 1ns/100ps
`include "tx_dsp_params.svh"

module tx_nco_rotate
   import tx_dsp_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        run_i,
   input  logic [31:0] phase_inc_i,
   input  iq_wide_t    data_i,
   output iq_wide_t    data_o
);

   localparam int ZW = `TX_CORDIC_W;
   localparam int W  = `TX_CORDIC_W + 2;   // Guard bits for gain and rotation
   localparam int N  = `TX_CORDIC_STAGES;

   logic [31:0]          phase;
   logic [ZW-1:0]        z_in;
   logic signed [W-1:0]  x_in;
   logic signed [W-1:0]  y_in;
   logic signed [W-1:0]  x_s [N+1];
   logic signed [W-1:0]  y_s [N+1];
   logic signed [ZW-1:0] z_s [N];

   // Phase accumulator, idle at zero
   always_ff @(posedge clk) begin
      if (rst || !run_i)
         phase <= '0;
      else
         phase <= phase + phase_inc_i;
   end

   assign z_in = phase[31 -: ZW];

   assign x_in = {{(W-ZW){data_i.i[`TX_BB_W-1]}}, data_i.i, {(ZW-`TX_BB_W){1'b0}}};
   assign y_in = {{(W-ZW){data_i.q[`TX_BB_W-1]}}, data_i.q, {(ZW-`TX_BB_W){1'b0}}};

   // Pre-rotation into +/- a quarter turn
   always_ff @(posedge clk) begin
      if (rst) begin
         x_s[0] <= '0;
         y_s[0] <= '0;
         z_s[0] <= '0;
      end else if (z_in[ZW-1] ^ z_in[ZW-2]) begin   // Second or third quadrant
         x_s[0] <= -x_in;
         y_s[0] <= -y_in;
         z_s[0] <= {~z_in[ZW-1], z_in[ZW-2:0]};
      end else begin
         x_s[0] <= x_in;
         y_s[0] <= y_in;
         z_s[0] <= z_in;
      end
   end

   for (genvar k = 0; k < N; k++) begin : g_stage
      logic signed [W-1:0] x_sh;
      logic signed [W-1:0] y_sh;
      logic                rot_neg;

      assign x_sh    = x_s[k] >>> k;
      assign y_sh    = y_s[k] >>> k;
      assign rot_neg = z_s[k][ZW-1];   // Residual angle below zero

      always_ff @(posedge clk) begin
         if (rst) begin
            x_s[k+1] <= '0;
            y_s[k+1] <= '0;
         end else if (rot_neg) begin
            x_s[k+1] <= x_s[k] + y_sh;
            y_s[k+1] <= y_s[k] - x_sh;
         end else begin
            x_s[k+1] <= x_s[k] - y_sh;
            y_s[k+1] <= y_s[k] + x_sh;
         end
      end

      // Last stage needs no residual angle
      if (k < N - 1) begin : g_z
         always_ff @(posedge clk) begin
            if (rst)
               z_s[k+1] <= '0;
            else if (rot_neg)
               z_s[k+1] <= z_s[k] + cordic_atan_table[k];
            else
               z_s[k+1] <= z_s[k] - cordic_atan_table[k];
         end
      end
   end

   assign data_o = '{i: x_s[N][W-1 -: `TX_BB_W], q: y_s[N][W-1 -: `TX_BB_W]};

endmodule

/* rtl/tx_cic_interp.sv */
// CIC interpolator for rates 2**log2_rate_i; the framer must hold a new sample after every strobe
`timescale 1ns/100ps
`include "tx_dsp_params.svh"

module tx_cic_interp
   import tx_dsp_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       run_i,
   input  logic       rate_change_i,
   input  logic [2:0] log2_rate_i,
   input  iq_sample_t sample_i,
   output logic       sample_stb_o,
   output iq_wide_t   cic_o
);

   // Room for the full CIC growth, wrap-around is harmless
   localparam int ACC_W = `TX_BB_W + `TX_CIC_N * `TX_MAX_LOG2_RATE;
   localparam int LR    = `TX_MAX_LOG2_RATE;

   logic                       enable;
   logic [LR-1:0]              rate_cnt;
   logic [LR-1:0]              rate_last;
   logic signed [`TX_BB_W-1:0] bb_in  [2];
   logic signed [`TX_BB_W-1:0] bb_out [2];

   assign enable    = run_i & ~rate_change_i;
   assign rate_last = {LR{1'b1}} >> (LR - log2_rate_i);   // 2**log2 - 1

   // Rate strober
   always_ff @(posedge clk) begin
      if (rst || !enable)
         rate_cnt <= '0;
      else if (rate_cnt == rate_last)
         rate_cnt <= '0;
      else
         rate_cnt <= rate_cnt + 1'b1;
   end

   assign sample_stb_o = enable && (rate_cnt == '0);

   // Two guard bits below the 16-bit sample
   assign bb_in[0] = {sample_i.i, 2'b00};
   assign bb_in[1] = {sample_i.q, 2'b00};

   for (genvar ch = 0; ch < 2; ch++) begin : g_chan
      logic signed [ACC_W-1:0] comb   [`TX_CIC_N+1];
      logic signed [ACC_W-1:0] comb_d [`TX_CIC_N];
      logic signed [ACC_W-1:0] integ  [`TX_CIC_N];
      logic signed [ACC_W-1:0] norm;

      assign comb[0] = ACC_W'(bb_in[ch]);   // Sign extend

      // Comb differences, evaluated at the sample rate
      for (genvar k = 0; k < `TX_CIC_N; k++) begin : g_comb
         assign comb[k+1] = comb[k] - comb_d[k];
      end

      always_ff @(posedge clk) begin
         if (rst || !enable) begin
            comb_d <= '{default: '0};
            integ  <= '{default: '0};
         end else begin
            if (sample_stb_o) begin
               for (int k = 0; k < `TX_CIC_N; k++)
                  comb_d[k] <= comb[k];
            end
            // Zero stuffing between strobes
            integ[0] <= integ[0] + (sample_stb_o ? comb[`TX_CIC_N] : '0);
            for (int k = 1; k < `TX_CIC_N; k++)
               integ[k] <= integ[k] + integ[k-1];
         end
      end

      // DC gain is rate**(N-1), removed exactly
      assign norm        = integ[`TX_CIC_N-1] >>> (log2_rate_i * (`TX_CIC_N - 1));
      assign bb_out[ch]  = norm[`TX_BB_W-1:0];
   end

   assign cic_o = '{i: bb_out[0], q: bb_out[1]};

endmodule

/* rtl/tx_setting_decode.sv */
// Settings register file; writes land in cfg_o one cycle after the strobe, unknown addresses dropped
`timescale 1ns/100ps
`include "tx_dsp_params.svh"

module tx_setting_decode
   import tx_dsp_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          set_stb_i,
   input  logic [7:0]    set_addr_i,
   input  setting_word_u set_data_i,
   output tx_cfg_t       cfg_o,
   output logic          rate_change_o
);

   logic hit_freq;
   logic hit_scale;
   logic hit_rate;

   assign hit_freq  = set_stb_i && (set_addr_i == `TX_ADDR_FREQ);
   assign hit_scale = set_stb_i && (set_addr_i == `TX_ADDR_SCALE);
   assign hit_rate  = set_stb_i && (set_addr_i == `TX_ADDR_RATE);

   // NCO frequency word
   always_ff @(posedge clk) begin
      if (rst)
         cfg_o.phase_inc <= '0;
      else if (hit_freq)
         cfg_o.phase_inc <= set_data_i.raw;
   end

   // Per channel gain
   always_ff @(posedge clk) begin
      if (rst)
         cfg_o.scale <= '0;
      else if (hit_scale)
         cfg_o.scale <= set_data_i.scale;
   end

   // Interpolation rate, with a pulse so the CIC restarts cleanly
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_o.log2_rate <= '0;
         rate_change_o   <= 1'b0;
      end else begin
         rate_change_o <= hit_rate;
         if (hit_rate)
            cfg_o.log2_rate <= set_data_i.rate.log2_rate;
      end
   end

endmodule

/* rtl/tx_dsp_pkg.sv */
// Shared TX DSP types; the arctangent table is in units of 2^-24 turn and sized to the stage count
`include "tx_dsp_params.svh"

package tx_dsp_pkg;

   // One framer word, i in the upper half
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq_sample_t;

   typedef struct packed {
      logic signed [`TX_BB_W-1:0] i;
      logic signed [`TX_BB_W-1:0] q;
   } iq_wide_t;

   typedef struct packed {
      logic signed [`TX_DAC_W-1:0] i;
      logic signed [`TX_DAC_W-1:0] q;
   } iq_dac_t;

   typedef struct packed {
      logic signed [15:0] scale_i;
      logic signed [15:0] scale_q;
   } scale_t;

   typedef struct packed {
      logic [28:0] pad;   // Ignored
      logic [2:0]  log2_rate;
   } rate_t;

   // Settings data, meaning depends on the address
   typedef union packed {
      logic [31:0] raw;
      scale_t      scale;
      rate_t       rate;
   } setting_word_u;

   typedef struct packed {
      logic [31:0] phase_inc;
      scale_t      scale;
      logic [2:0]  log2_rate;
   } tx_cfg_t;

   // atan(2^-k) with 2^24 as one full turn
   localparam logic [23:0] cordic_atan_table [`TX_CORDIC_STAGES] = '{
      24'd2097152, 24'd1238021, 24'd654136, 24'd332050,
      24'd166669,  24'd83416,   24'd41718,  24'd20860,
      24'd10430,   24'd5215,    24'd2608,   24'd1304,
      24'd652,     24'd326,     24'd163,    24'd81
   };

endpackage

/* rtl/tx_dsp_params.svh */
// Register map and widths for the TX DSP core; log2 rate must stay within 0 to TX_MAX_LOG2_RATE
`ifndef TX_DSP_PARAMS_SVH
`define TX_DSP_PARAMS_SVH

// Settings bus addresses
`define TX_ADDR_FREQ        8'd0
`define TX_ADDR_SCALE       8'd1
`define TX_ADDR_RATE        8'd2

// Datapath widths
`define TX_BB_W             18
`define TX_CORDIC_W         24
`define TX_DAC_W            24

// CORDIC depth, one stage per table entry
`define TX_CORDIC_STAGES    16

// CIC order and largest interpolation, rate is 2**log2
`define TX_CIC_N            2
`define TX_MAX_LOG2_RATE    7

`endif
